/* common/viper_pkg.sv */
// shared widths, field enums and the instruction word layout
// wishbone request/response structs and the internal bus command

package viper_pkg;

   localparam int addr_w  = 20;  // external bus address
   localparam int data_w  = 32;  // registers and bus data
   localparam int pc_step = 8;   // reg3 advance per fetch
   localparam int tail_w  = 19;  // immediate / offset field

   typedef enum logic [1:0] {
      reg0, reg1, reg2, reg3
   } reg_sel_e;

   typedef enum logic [1:0] {
      immediate, direct, index_reg1, index_reg2
   } addr_mode_e;

   typedef enum logic [2:0] {
      dest_reg0, dest_reg1, dest_reg2, dest_reg3,
      cond_set, cond_clear, dest_none, store
   } dest_e;

   // register group, 12 and up are reserved
   typedef enum logic [3:0] {
      neg, push, load_a, load_b, add_a, add_b, sub_a, sub_b,
      add_c, sub_c, add_d, sub_d, reserved
   } alu_func_e;

   // upper half ors the result into the old flag
   typedef enum logic [3:0] {
      lt, ge, eq, ne, le, gt, rsv6, rsv7,
      lt_or, ge_or, eq_or, ne_or, le_or, gt_or, rsv14, rsv15
   } cmp_func_e;

   typedef struct packed {
      logic                top;         // sign bit, ignored
      reg_sel_e            src;
      addr_mode_e          mode;
      dest_e               dest;
      logic                is_compare;
      logic [3:0]          func;        // alu_func_e or cmp_func_e
      logic [tail_w-1:0]   tail;
   } instr_t;

   typedef logic [3:0][data_w-1:0] reg_bank_t;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [addr_w-1:0] adr;
      logic [data_w-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [data_w-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic              go;   // one cycle, master idle only
      logic              we;
      logic [addr_w-1:0] adr;
      logic [data_w-1:0] dat;
   } bus_cmd_t;

   typedef enum logic [1:0] {
      fetch, operand, execute, store_wait
   } seq_state_e;

endpackage

/* source/wb_master.sv */
// wishbone classic master, one transfer at a time
// holds the request until ack, then pulses done with the read data

`timescale 1ns/1ps

module wb_master (
   input  logic                             clock,
   input  logic                             reset,
   input  viper_pkg::bus_cmd_t              cmd,
   output viper_pkg::wb_req_t               bus,
   input  viper_pkg::wb_rsp_t               bus_rsp,
   output logic                             done,
   output logic [viper_pkg::data_w-1:0]     rdata
);

   import viper_pkg::*;

   logic              busy;   // cyc and stb
   logic              we_q;
   logic [addr_w-1:0] adr_q;
   logic [data_w-1:0] dat_q;

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         we_q <= 1'b0;
         done <= 1'b0;
      end
      else
      begin
         done <= busy && bus_rsp.ack;
         if (busy)
         begin
            if (bus_rsp.ack)
               busy <= 1'b0;   // cyc drops the cycle after ack
         end
         else if (cmd.go)
         begin
            busy <= 1'b1;
            we_q <= cmd.we;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (!busy && cmd.go)
      begin
         adr_q <= cmd.adr;
         dat_q <= cmd.dat;
      end
      if (busy && bus_rsp.ack && !we_q)
         rdata <= bus_rsp.dat;   // held until the next read
   end

   always_comb
   begin
      bus.cyc = busy;
      bus.stb = busy;
      bus.we  = we_q;
      bus.adr = adr_q;
      bus.dat = dat_q;
   end

endmodule

/* source/sequencer.sv */
// instruction sequencer FSM
// fetch, optional operand read or store write, one execute cycle

`timescale 1ns/1ps

module sequencer (
   input  logic                             clock,
   input  logic                             reset,
   input  viper_pkg::instr_t                instr,
   input  logic                             done,
   input  logic [viper_pkg::addr_w-1:0]     pc,
   input  logic [viper_pkg::addr_w-1:0]     eff_addr,
   input  logic [viper_pkg::data_w-1:0]     store_data,
   input  logic                             needs_operand,
   input  logic                             is_store,
   output viper_pkg::bus_cmd_t              cmd,
   output logic                             ir_load,
   output logic                             pc_advance,
   output logic                             exec_strobe
);

   import viper_pkg::*;

   seq_state_e state;
   seq_state_e state_next;
   logic       waiting;   // transfer issued, done not yet seen

   always_comb
   begin
      state_next = state;
      case (state)
         fetch:
         begin
            if (done)
            begin
               if (is_store)
                  state_next = store_wait;
               else if (needs_operand)
                  state_next = operand;
               else
                  state_next = execute;
            end
         end
         operand:
         begin
            if (done)
               state_next = execute;
         end
         execute:
            state_next = fetch;   // always a single cycle
         store_wait:
         begin
            if (done)
               state_next = fetch;
         end
         default:
            state_next = fetch;
      endcase
   end

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         state   <= fetch;
         waiting <= 1'b0;
      end
      else
      begin
         state <= state_next;
         if (cmd.go)
            waiting <= 1'b1;
         else if (done)
            waiting <= 1'b0;
      end
   end

   // one request per bus phase, issued on entry to the state
   always_comb
   begin
      cmd.go  = (state != execute) && !waiting;
      cmd.we  = (state == store_wait) && !instr.is_compare && (instr.dest == store);
      cmd.adr = (state == fetch) ? pc : eff_addr;
      cmd.dat = store_data;
   end

   assign ir_load     = (state == fetch) && done;
   assign pc_advance  = (state == fetch) && done;   // reg3 += 8 with the IR load
   assign exec_strobe = (state == execute);

endmodule

/* datapath/reg_file.sv */
// four 32-bit registers, reg3 is the program counter
// pc increment, push and single register writes

`timescale 1ns/1ps

module reg_file (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             pc_advance,
   input  logic [3:0]                       wr_en,
   input  logic [viper_pkg::data_w-1:0]     wr_value,
   input  logic                             push,
   input  logic [viper_pkg::data_w-1:0]     operand,
   output viper_pkg::reg_bank_t             regs
);

   import viper_pkg::*;

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         regs <= '0;
      end
      else if (push)
      begin
         regs[2] <= regs[3];   // old pc saved in reg2
         regs[3] <= operand;
      end
      else
      begin
         for (int i = 0; i < 4; i++)
         begin
            if (wr_en[i])
               regs[i] <= wr_value;
         end
         if (pc_advance)
            regs[3] <= regs[3] + data_w'(pc_step);   // wraps at 32 bits
      end
   end

endmodule

/* datapath/exec_unit.sv */
// instruction register, field decode and effective address
// compare flag, ALU result and register write enables

`timescale 1ns/1ps

module exec_unit (
   input  logic                             clock,
   input  logic                             reset,
   input  logic [viper_pkg::data_w-1:0]     rdata,
   input  logic                             ir_load,
   input  logic                             exec_strobe,
   input  viper_pkg::reg_bank_t             regs,
   output viper_pkg::instr_t                instr,
   output logic [viper_pkg::addr_w-1:0]     eff_addr,
   output logic [viper_pkg::data_w-1:0]     store_data,
   output logic                             needs_operand,
   output logic                             is_store,
   output logic [3:0]                       wr_en,
   output logic [viper_pkg::data_w-1:0]     wr_value,
   output logic                             push,
   output logic [viper_pkg::data_w-1:0]     operand
);

   import viper_pkg::*;

   instr_t            dec;        // word being decoded
   logic              flag;
   logic              cmp_base;
   logic              cmp_hit;
   logic              lt_s;
   logic              gt_s;
   logic              reserved_op;
   logic              alu_op;
   logic [data_w-1:0] src_val;
   logic [addr_w-1:0] index;

   function automatic logic func_reserved(instr_t i);
      if (i.is_compare)
         return cmp_func_e'(i.func) inside {rsv6, rsv7, rsv14, rsv15};
      return i.func >= reserved;
   endfunction

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         instr <= '0;
         flag  <= 1'b0;
      end
      else
      begin
         if (ir_load)
            instr <= dec;
         if (exec_strobe && instr.is_compare && !reserved_op)
            flag <= cmp_hit;
      end
   end

   // the sequencer branches on the fetched word in the cycle it is loaded
   assign dec           = ir_load ? instr_t'(rdata) : instr;
   assign is_store      = !dec.is_compare && (dec.dest == store);
   assign needs_operand = (dec.mode != immediate) && !is_store && !func_reserved(dec);

   assign reserved_op = func_reserved(instr);
   assign src_val     = regs[instr.src];
   assign store_data  = src_val;
   assign operand     = (instr.mode == immediate) ? data_w'(instr.tail) : rdata;

   always_comb
   begin
      case (instr.mode)
         index_reg1: index = regs[1][addr_w-1:0];
         index_reg2: index = regs[2][addr_w-1:0];
         default:    index = '0;
      endcase
      eff_addr = addr_w'(instr.tail) + index;   // 20-bit wrap
   end

   always_comb
   begin
      lt_s = $signed(src_val) < $signed(operand);
      gt_s = $signed(src_val) > $signed(operand);
      case (cmp_func_e'({1'b0, instr.func[2:0]}))
         lt:      cmp_base = lt_s;
         ge:      cmp_base = !lt_s;
         eq:      cmp_base = (src_val == operand);
         ne:      cmp_base = (src_val != operand);
         le:      cmp_base = !gt_s;
         gt:      cmp_base = gt_s;
         default: cmp_base = flag;
      endcase
      cmp_hit = cmp_base | (instr.func[3] & flag);   // or variants keep a set flag
   end

   always_comb
   begin
      case (alu_func_e'(instr.func))
         neg:                          wr_value = '0 - operand;
         viper_pkg::push, load_a, load_b: wr_value = operand;
         add_a, add_b, add_c, add_d:   wr_value = src_val + operand;
         sub_a, sub_b, sub_c, sub_d:   wr_value = src_val - operand;
         default:                      wr_value = src_val;
      endcase
   end

   assign alu_op = exec_strobe && !instr.is_compare && !reserved_op;
   assign push   = alu_op && (alu_func_e'(instr.func) == viper_pkg::push);

   always_comb
   begin
      wr_en = 4'b0000;
      if (alu_op && !push)
      begin
         case (instr.dest)
            dest_reg0:  wr_en = 4'b0001;
            dest_reg1:  wr_en = 4'b0010;
            dest_reg2:  wr_en = 4'b0100;
            dest_reg3:  wr_en = 4'b1000;
            cond_set:   wr_en = {flag, 3'b000};    // jump when flag set
            cond_clear: wr_en = {!flag, 3'b000};
            default:    wr_en = 4'b0000;           // dest_none writes nothing
         endcase
      end
   end

endmodule

/* source/viper_top.sv */
// processor top level
// sequencer, wishbone master, register file and execute unit

`timescale 1ns/1ps

module viper_top (
   input  logic               clock,
   input  logic               reset,
   output viper_pkg::wb_req_t bus,
   input  viper_pkg::wb_rsp_t bus_rsp
);

   import viper_pkg::*;

   bus_cmd_t          cmd;
   logic              done;
   logic [data_w-1:0] rdata;
   instr_t            instr;
   logic [addr_w-1:0] eff_addr;
   logic [data_w-1:0] store_data;
   logic              needs_operand;
   logic              is_store;
   logic              ir_load;
   logic              pc_advance;
   logic              exec_strobe;
   reg_bank_t         regs;
   logic [3:0]        wr_en;
   logic [data_w-1:0] wr_value;
   logic              push;
   logic [data_w-1:0] operand;

   sequencer sequencer_i (
      .clock         (clock),
      .reset         (reset),
      .instr         (instr),
      .done          (done),
      .pc            (regs[3][addr_w-1:0]),  // fetch from low bits of reg3
      .eff_addr      (eff_addr),
      .store_data    (store_data),
      .needs_operand (needs_operand),
      .is_store      (is_store),
      .cmd           (cmd),
      .ir_load       (ir_load),
      .pc_advance    (pc_advance),
      .exec_strobe   (exec_strobe)
   );

   wb_master wb_master_i (
      .clock   (clock),
      .reset   (reset),
      .cmd     (cmd),
      .bus     (bus),
      .bus_rsp (bus_rsp),
      .done    (done),
      .rdata   (rdata)
   );

   reg_file reg_file_i (
      .clock      (clock),
      .reset      (reset),
      .pc_advance (pc_advance),
      .wr_en      (wr_en),
      .wr_value   (wr_value),
      .push       (push),
      .operand    (operand),
      .regs       (regs)
   );

   exec_unit exec_unit_i (
      .clock         (clock),
      .reset         (reset),
      .rdata         (rdata),
      .ir_load       (ir_load),
      .exec_strobe   (exec_strobe),
      .regs          (regs),
      .instr         (instr),
      .eff_addr      (eff_addr),
      .store_data    (store_data),
      .needs_operand (needs_operand),
      .is_store      (is_store),
      .wr_en         (wr_en),
      .wr_value      (wr_value),
      .push          (push),
      .operand       (operand)
   );

endmodule

/* testbench/tb_clock.sv */
// clock and reset generator for the testbench

`timescale 1ns/1ps

module tb_clock (
   output logic clock,
   output logic reset
);

   initial
   begin
      clock = 1'b0;
      forever #50 clock = ~clock;   // 100 ns period
   end

   initial
   begin
      reset = 1'b1;
      repeat (8) @(posedge clock);
      reset <= 1'b0;
   end

endmodule

/* testbench/wb_memory.sv */
// wishbone classic memory model, 1K words
// random ack delay of 0 to 3 cycles and a log of every write

`timescale 1ns/1ps

module wb_memory (
   input  logic               clock,
   input  logic               reset,
   input  viper_pkg::wb_req_t bus,
   output viper_pkg::wb_rsp_t bus_rsp
);

   import viper_pkg::*;

   logic [data_w-1:0] mem [0:1023];   // filled by the testbench
   logic [addr_w-1:0] log_adr [$];
   logic [data_w-1:0] log_dat [$];
   integer            seed = 32'hbe43be55;
   int                wait_left;

   initial
   begin
      bus_rsp   = '0;
      wait_left = 0;
   end

   always @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         bus_rsp   <= '0;
         wait_left <= 0;
      end
      else if (bus_rsp.ack)
         bus_rsp.ack <= 1'b0;   // master drops stb after the ack edge
      else if (bus.cyc && bus.stb)
      begin
         if (wait_left > 0)
            wait_left <= wait_left - 1;
         else
         begin
            bus_rsp.ack <= 1'b1;
            if (bus.we)
            begin
               mem[bus.adr[9:0]] <= bus.dat;
               log_adr.push_back(bus.adr);
               log_dat.push_back(bus.dat);
            end
            else
               bus_rsp.dat <= mem[bus.adr[9:0]];
            wait_left <= $unsigned($random(seed)) % 4;   // delay of the next transfer
         end
      end
   end

endmodule

/* testbench/viper_props.sv */
// wishbone protocol assertions bound into the processor top level

`timescale 1ns/1ps

module viper_props (
   input logic               clock,
   input logic               reset,
   input viper_pkg::wb_req_t bus,
   input viper_pkg::wb_rsp_t bus_rsp,
   input logic               done
);

   int   fail_count = 0;   // watched by the testbench
   logic seen_req;

   always @(posedge clock or posedge reset)
   begin
      if (reset)
         seen_req <= 1'b0;
      else if (bus.stb)
         seen_req <= 1'b1;
   end

   reset_idle: assert property (@(posedge clock) reset |-> !bus.cyc && !bus.stb)
      else begin $error("bus active during reset"); fail_count++; end

   stb_in_cyc: assert property (@(posedge clock) disable iff (reset) bus.stb |-> bus.cyc)
      else begin $error("stb high without cyc"); fail_count++; end

   req_stable: assert property (@(posedge clock) disable iff (reset)
      bus.stb && !bus_rsp.ack |=> bus.stb && $stable(bus.adr) && $stable(bus.we)
                                  && $stable(bus.dat))
      else begin $error("request changed before ack"); fail_count++; end

   drop_after_ack: assert property (@(posedge clock) disable iff (reset)
      bus.stb && bus_rsp.ack |=> !bus.stb && !bus.cyc && done)
      else begin $error("no release or done after ack"); fail_count++; end

   first_fetch: assert property (@(posedge clock) disable iff (reset)
      !seen_req && bus.stb |-> !bus.we && bus.adr == '0)
      else begin $error("first request is not a read at address 0"); fail_count++; end

endmodule

/* testbench/viper_tb.sv */
// testbench top with program image and reference run of the program
// per-transfer bus checks, store log comparison and timeout

`timescale 1ns/1ps

module viper_tb;

   import viper_pkg::*;

   localparam int max_cycles = 4000;   // about 40 instructions of up to 12 cycles plus margin

   logic              clock;
   logic              reset;
   wb_req_t           bus;
   wb_rsp_t           bus_rsp;
   logic [data_w-1:0] ref_mem [0:1023];
   logic              exp_we  [$];
   logic [addr_w-1:0] exp_adr [$];
   logic [data_w-1:0] exp_dat [$];
   logic [addr_w-1:0] exp_st_adr [$];
   logic [data_w-1:0] exp_st_dat [$];
   integer            seed = 32'hbe43be55;
   int                cycles = 0;
   int                checked = 0;
   logic              stb_seen = 1'b0;
   logic              stb_rose;

   tb_clock  clock_i (.clock(clock), .reset(reset));
   wb_memory mem_i (.clock(clock), .reset(reset), .bus(bus), .bus_rsp(bus_rsp));
   viper_top viper_top_i (.clock(clock), .reset(reset), .bus(bus), .bus_rsp(bus_rsp));

   bind viper_top viper_props props_i (
      .clock(clock), .reset(reset), .bus(bus), .bus_rsp(bus_rsp), .done(done));

   task automatic abort_run(string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "run stopped");
   endtask

   task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
      abort_run($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, got));
   endtask

   function automatic instr_t encode(reg_sel_e s, addr_mode_e m, dest_e d, logic c,
                                     logic [3:0] f, logic [tail_w-1:0] t);
      encode = '{top: 1'b0, src: s, mode: m, dest: d, is_compare: c, func: f, tail: t};
   endfunction

   task automatic place(int n, instr_t w);
      ref_mem[n * pc_step] = w;   // instruction n sits at byte address n*8
   endtask

   task automatic add_expected(logic we, logic [addr_w-1:0] adr, logic [data_w-1:0] dat);
      exp_we.push_back(we);
      exp_adr.push_back(adr);
      exp_dat.push_back(dat);
   endtask

   task automatic load_program();
      place(0,  encode(reg0, immediate,  dest_reg0,  0, load_a,   'h1234));
      place(1,  encode(reg0, immediate,  dest_reg1,  0, load_b,   'h5));
      place(2,  encode(reg0, immediate,  dest_reg2,  0, load_a,   'h10));
      place(3,  encode(reg0, immediate,  store,      0, load_a,   'h300));
      place(4,  encode(reg0, direct,     dest_reg0,  0, add_a,    'h200));
      place(5,  encode(reg1, index_reg1, dest_reg1,  0, sub_a,    'h200));
      place(6,  encode(reg0, index_reg2, dest_reg0,  0, add_b,    'h200));
      place(7,  encode(reg0, index_reg2, store,      0, load_a,   'h300));
      place(8,  encode(reg1, immediate,  store,      0, load_a,   'h301));
      place(9,  encode(reg0, direct,     dest_reg0,  0, neg,      'h203));
      place(10, encode(reg0, immediate,  store,      0, load_a,   'h302));
      place(11, encode(reg0, immediate,  dest_none,  0, push,     'h68));
      place(12, encode(reg0, immediate,  store,      0, load_a,   'h3ff));   // skipped
      place(13, encode(reg2, immediate,  store,      0, load_a,   'h303));
      place(14, encode(reg0, immediate,  dest_reg1,  0, load_a,   'h3));
      place(15, encode(reg1, immediate,  dest_none,  1, eq,       'h3));
      place(16, encode(reg0, immediate,  cond_set,   0, load_a,   'h90));
      place(17, encode(reg1, immediate,  store,      0, load_a,   'h3fe));   // skipped
      place(18, encode(reg1, immediate,  dest_none,  1, ne,       'h3));
      place(19, encode(reg0, immediate,  cond_set,   0, load_a,   'h1f8));   // not taken
      place(20, encode(reg0, immediate,  cond_clear, 0, load_a,   'hb0));
      place(21, encode(reg1, immediate,  store,      0, load_a,   'h3fd));   // skipped
      place(22, encode(reg1, immediate,  dest_none,  1, eq,       'h3));
      place(23, encode(reg1, immediate,  dest_none,  1, ne_or,    'h3));     // flag stays set
      place(24, encode(reg0, immediate,  cond_set,   0, load_a,   'hd0));
      place(25, encode(reg1, immediate,  store,      0, load_a,   'h3fc));   // skipped
      place(26, encode(reg0, direct,     dest_none,  1, lt,       'h201));
      place(27, encode(reg0, immediate,  cond_clear, 0, load_a,   'he8));
      place(28, encode(reg0, immediate,  store,      0, load_a,   'h304));   // data dependent
      place(29, encode(reg0, direct,     dest_none,  1, rsv6,     'h202));
      place(30, encode(reg1, direct,     dest_reg1,  0, add_c,    'h206));
      place(31, encode(reg1, direct,     dest_reg1,  0, sub_d,    'h207));
      place(32, encode(reg1, direct,     dest_reg1,  0, reserved, 'h208));
      place(33, encode(reg1, immediate,  store,      0, load_a,   'h305));
      place(34, encode(reg0, immediate,  dest_reg1,  0, load_b,   'h2c));
      place(35, encode(reg1, immediate,  store,      0, load_a,   'h306));
      place(36, encode(reg0, immediate,  dest_reg2,  0, load_a,   'h2d));
      place(37, encode(reg2, immediate,  store,      0, load_a,   'h307));
      place(38, encode(reg3, immediate,  store,      0, load_a,   'h308));   // advanced pc
      place(39, encode(reg0, immediate,  dest_reg3,  0, load_a,   'h138));   // jumps to itself
   endtask

   // instruction-level model of the processor that builds the expected bus transfers
   task automatic run_reference();
      logic [data_w-1:0] r [4];
      logic              flag;
      logic              halt;
      logic              rsv;
      logic              base;
      instr_t            ir;
      logic [addr_w-1:0] pc;
      logic [addr_w-1:0] ea;
      logic [data_w-1:0] src;
      logic [data_w-1:0] opnd;
      logic [data_w-1:0] res;
      for (int i = 0; i < 4; i++)
         r[i] = '0;
      flag = 1'b0;
      halt = 1'b0;
      while (!halt && exp_adr.size() < 400)
      begin
         pc = r[3][addr_w-1:0];
         ir = instr_t'(ref_mem[pc[9:0]]);
         add_expected(1'b0, pc, '0);
         r[3] = r[3] + pc_step;
         halt = !ir.is_compare && ir.func == load_a && ir.mode == immediate
                && ir.dest == dest_reg3 && ir.tail == pc;
         src  = r[ir.src];
         ea   = addr_w'(ir.tail);
         if (ir.mode == index_reg1)
            ea = ea + r[1][addr_w-1:0];
         else if (ir.mode == index_reg2)
            ea = ea + r[2][addr_w-1:0];
         rsv = ir.is_compare ? (ir.func[2:1] == 2'b11) : (ir.func >= 4'd12);
         if (!ir.is_compare && ir.dest == store)
         begin
            add_expected(1'b1, ea, src);
            ref_mem[ea[9:0]] = src;
            exp_st_adr.push_back(ea);
            exp_st_dat.push_back(src);
         end
         else if (!rsv)
         begin
            if (ir.mode == immediate)
               opnd = data_w'(ir.tail);
            else
            begin
               add_expected(1'b0, ea, '0);
               opnd = ref_mem[ea[9:0]];
            end
            if (ir.is_compare)
            begin
               case (ir.func[2:0])
                  3'd0:    base = $signed(src) < $signed(opnd);
                  3'd1:    base = $signed(src) >= $signed(opnd);
                  3'd2:    base = src == opnd;
                  3'd3:    base = src != opnd;
                  3'd4:    base = $signed(src) <= $signed(opnd);
                  default: base = $signed(src) > $signed(opnd);
               endcase
               flag = base | (ir.func[3] & flag);
            end
            else if (ir.func == push)
            begin
               r[2] = r[3];
               r[3] = opnd;
            end
            else
            begin
               case (alu_func_e'(ir.func))
                  neg:                        res = -opnd;
                  add_a, add_b, add_c, add_d: res = src + opnd;
                  sub_a, sub_b, sub_c, sub_d: res = src - opnd;
                  default:                    res = opnd;
               endcase
               if (ir.dest <= dest_reg3)
                  r[ir.dest[1:0]] = res;
               else if ((ir.dest == cond_set && flag) || (ir.dest == cond_clear && !flag))
                  r[3] = res;
            end
         end
      end
   endtask

   initial
   begin
      for (int i = 0; i < 1024; i++)
         ref_mem[i] = '0;
      load_program();
      for (int i = 0; i < 32; i++)
         ref_mem['h200 + i] = $random(seed);   // operand data
      for (int i = 0; i < 1024; i++)
         mem_i.mem[i] = ref_mem[i];
      run_reference();
   end

   task automatic check_transfer();
      assert (bus.we == exp_we[checked])
         else report_mismatch("bus.we", exp_we[checked], bus.we);
      assert (bus.adr == exp_adr[checked])
         else report_mismatch("bus.adr", exp_adr[checked], bus.adr);
      if (bus.we)
         assert (bus.dat == exp_dat[checked])
            else report_mismatch("bus.dat", exp_dat[checked], bus.dat);
      checked++;
   endtask

   task automatic finish_run();
      int mismatches;
      mismatches = 0;
      if (mem_i.log_adr.size() != exp_st_adr.size())
         mismatches++;
      else
         for (int i = 0; i < exp_st_adr.size(); i++)
            if (mem_i.log_adr[i] != exp_st_adr[i] || mem_i.log_dat[i] != exp_st_dat[i])
               mismatches++;
      if (mismatches == 0)
      begin
         $display("** PASS **");
         $finish;
      end
      else
         abort_run("store log does not match the expected writes");
   endtask

   // one check per bus transfer, taken at the falling edge
   always @(negedge clock)
   begin
      if (!reset)
      begin
         cycles++;
         stb_rose = bus.stb && !stb_seen;
         stb_seen = bus.stb;
         if (viper_top_i.props_i.fail_count != 0)
            abort_run("a bus protocol assertion failed");
         else if (cycles >= max_cycles)
            abort_run("timeout, the program never reached its final instruction");
         else if (stb_rose)
         begin
            check_transfer();
            if (checked == exp_adr.size())
               finish_run();   // last fetch is the self jump
         end
      end
   end

endmodule

/* flist.f */
common/viper_pkg.sv
source/wb_master.sv
source/sequencer.sv
datapath/reg_file.sv
datapath/exec_unit.sv
source/viper_top.sv
testbench/tb_clock.sv
testbench/wb_memory.sv
testbench/viper_props.sv
testbench/viper_tb.sv

/* Bender.yml */
package:
  name: viper

sources:
  - common/viper_pkg.sv
  - source/wb_master.sv
  - source/sequencer.sv
  - datapath/reg_file.sv
  - datapath/exec_unit.sv
  - source/viper_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/wb_memory.sv
      - testbench/viper_props.sv
      - testbench/viper_tb.sv
